// ==== include/bmu_cfg.svh ====
`ifndef BMU_CFG_SVH
`define BMU_CFG_SVH

// operand and result width
`define BMU_XLEN 32

// shift amount and bit index width is log2 of BMU_XLEN
`define BMU_SHAMT_W 5

// count results run 0 to BMU_XLEN inclusive
`define BMU_CNT_W 6

// extension enables where 1 turns the group on

// shNadd
`define BMU_ZBA_EN 1

// min/max, inverted logic ops, rotates, counts, sext, pack, rev8, orc.b
`define BMU_ZBB_EN 1

// single-bit set, clear, invert and extract
`define BMU_ZBS_EN 1

// packu
`define BMU_ZBP_EN 1

`endif

// ==== logic/bmu_pkg.sv ====
package bmu_pkg;

`include "bmu_cfg.svh"

  typedef logic [`BMU_XLEN-1:0]    word_t;
  typedef logic [`BMU_SHAMT_W-1:0] shamt_t;
  typedef logic [`BMU_CNT_W-1:0]   cnt_t;

  // codes 36..63 are not assigned and decode as illegal
  typedef enum logic [5:0] {
    OP_ADD    = 6'd0,
    OP_SUB    = 6'd1,
    OP_SLT    = 6'd2,
    OP_SLTU   = 6'd3,
    OP_SH1ADD = 6'd4,
    OP_SH2ADD = 6'd5,
    OP_SH3ADD = 6'd6,
    OP_MIN    = 6'd7,
    OP_MAX    = 6'd8,
    OP_MINU   = 6'd9,
    OP_MAXU   = 6'd10,
    OP_AND    = 6'd11,
    OP_OR     = 6'd12,
    OP_XOR    = 6'd13,
    OP_ANDN   = 6'd14,
    OP_ORN    = 6'd15,
    OP_XNOR   = 6'd16,
    OP_SLL    = 6'd17,
    OP_SRL    = 6'd18,
    OP_SRA    = 6'd19,
    OP_ROL    = 6'd20,
    OP_ROR    = 6'd21,
    OP_BEXT   = 6'd22,
    OP_BSET   = 6'd23,
    OP_BCLR   = 6'd24,
    OP_BINV   = 6'd25,
    OP_CLZ    = 6'd26,
    OP_CTZ    = 6'd27,
    OP_CPOP   = 6'd28,
    OP_SEXT_B = 6'd29,
    OP_SEXT_H = 6'd30,
    OP_PACK   = 6'd31,
    OP_PACKU  = 6'd32,
    OP_PACKH  = 6'd33,
    OP_REV8   = 6'd34,
    OP_ORC_B  = 6'd35
  } bmu_op_e;

  // which unit drives the result
  typedef enum logic [2:0] {
    SEL_NONE    = 3'd0,
    SEL_ADDER   = 3'd1,
    SEL_SHIFT   = 3'd2,
    SEL_BITWISE = 3'd3,
    SEL_COUNT   = 3'd4
  } bmu_sel_e;

endpackage

// ==== logic/bmu_decode.sv ====
`timescale 1ns/1ps

`include "bmu_cfg.svh"

module bmu_decode (
  input  bmu_pkg::bmu_op_e  op,
  output bmu_pkg::bmu_sel_e sel,
  output logic              illegal
);

  import bmu_pkg::*;

  localparam bit zba_en = (`BMU_ZBA_EN != 0);
  localparam bit zbb_en = (`BMU_ZBB_EN != 0);
  localparam bit zbs_en = (`BMU_ZBS_EN != 0);
  localparam bit zbp_en = (`BMU_ZBP_EN != 0);

  bmu_sel_e unit_sel;
  logic     ext_on;

  // unit and extension per code with undefined codes falling to default
  always_comb begin
    unit_sel = SEL_NONE;
    ext_on   = 1'b0;
    case (op)
      OP_ADD, OP_SUB, OP_SLT, OP_SLTU: begin
        unit_sel = SEL_ADDER;
        ext_on   = 1'b1;
      end
      OP_SH1ADD, OP_SH2ADD, OP_SH3ADD: begin
        unit_sel = SEL_ADDER;
        ext_on   = zba_en;
      end
      OP_MIN, OP_MAX, OP_MINU, OP_MAXU: begin
        unit_sel = SEL_ADDER;
        ext_on   = zbb_en;
      end
      OP_AND, OP_OR, OP_XOR: begin
        unit_sel = SEL_BITWISE;
        ext_on   = 1'b1;
      end
      OP_ANDN, OP_ORN, OP_XNOR, OP_SEXT_B, OP_SEXT_H,
      OP_PACK, OP_PACKH, OP_REV8, OP_ORC_B: begin
        unit_sel = SEL_BITWISE;
        ext_on   = zbb_en;
      end
      OP_PACKU: begin
        unit_sel = SEL_BITWISE;
        ext_on   = zbp_en;
      end
      OP_SLL, OP_SRL, OP_SRA: begin
        unit_sel = SEL_SHIFT;
        ext_on   = 1'b1;
      end
      OP_ROL, OP_ROR: begin
        unit_sel = SEL_SHIFT;
        ext_on   = zbb_en;
      end
      OP_BEXT: begin
        unit_sel = SEL_SHIFT;
        ext_on   = zbs_en;
      end
      OP_BSET, OP_BCLR, OP_BINV: begin
        unit_sel = SEL_BITWISE;
        ext_on   = zbs_en;
      end
      OP_CLZ, OP_CTZ, OP_CPOP: begin
        unit_sel = SEL_COUNT;
        ext_on   = zbb_en;
      end
      default: begin
        unit_sel = SEL_NONE;
        ext_on   = 1'b0;
      end
    endcase
  end

  assign illegal = ~ext_on;
  assign sel     = ext_on ? unit_sel : SEL_NONE;

endmodule

// ==== logic/bmu_adder.sv ====
`timescale 1ns/1ps

`include "bmu_cfg.svh"

module bmu_adder (
  input  bmu_pkg::bmu_op_e op,
  input  bmu_pkg::word_t   a_in,
  input  bmu_pkg::word_t   b_in,
  output bmu_pkg::word_t   result
);

  import bmu_pkg::*;

  localparam int msb = `BMU_XLEN - 1;

  word_t a_sh;
  word_t b_op;
  word_t sum;
  logic  cout;
  logic  sub_en;
  logic  cmp_unsigned;
  logic  ov;
  logic  lt;

  // shNadd scales rs1 before the add
  always_comb begin
    case (op)
      OP_SH1ADD: a_sh = a_in << 1;
      OP_SH2ADD: a_sh = a_in << 2;
      OP_SH3ADD: a_sh = a_in << 3;
      default:   a_sh = a_in;
    endcase
  end

  // compares reuse the subtract path
  assign sub_en = op inside {OP_SUB, OP_SLT, OP_SLTU, OP_MIN, OP_MAX, OP_MINU, OP_MAXU};
  assign cmp_unsigned = op inside {OP_SLTU, OP_MINU, OP_MAXU};

  assign b_op = sub_en ? ~b_in : b_in;

  assign {cout, sum} = {1'b0, a_sh} + {1'b0, b_op} + {{`BMU_XLEN{1'b0}}, sub_en};

  // signed overflow when both inputs agree in sign and the sum does not
  assign ov = (a_sh[msb] == b_op[msb]) && (sum[msb] != a_sh[msb]);

  // no carry out of a - b means a < b unsigned
  assign lt = cmp_unsigned ? ~cout : (sum[msb] ^ ov);

  always_comb begin
    case (op)
      OP_ADD, OP_SUB, OP_SH1ADD, OP_SH2ADD, OP_SH3ADD: result = sum;
      OP_SLT, OP_SLTU: result = {{msb{1'b0}}, lt};
      OP_MIN, OP_MINU: result = lt ? a_in : b_in;
      OP_MAX, OP_MAXU: result = lt ? b_in : a_in;
      default:         result = '0;
    endcase
  end

endmodule

// ==== logic/bmu_shifter.sv ====
`timescale 1ns/1ps

`include "bmu_cfg.svh"

module bmu_shifter (
  input  bmu_pkg::bmu_op_e op,
  input  bmu_pkg::word_t   a_in,
  input  bmu_pkg::word_t   b_in,
  output bmu_pkg::word_t   result
);

  import bmu_pkg::*;

  localparam int xlen = `BMU_XLEN;

  shamt_t                  b_amt;
  shamt_t                  amount;
  logic   [xlen-2:0]       ext_hi;
  logic   [2*xlen-2:0]     shift_ext;
  logic   [2*xlen-2:0]     shift_long;
  word_t                   shift_mask;
  logic                    left;

  assign b_amt = b_in[`BMU_SHAMT_W-1:0];

  // left shifts become a right shift by xlen - b that wraps 0 to 0
  assign left   = op inside {OP_SLL, OP_ROL};
  assign amount = left ? (shamt_t'(0) - b_amt) : b_amt;

  // upper half of the funnel
  always_comb begin
    case (op)
      OP_SRA:                 ext_hi = {(xlen-1){a_in[xlen-1]}};
      OP_SLL, OP_ROL, OP_ROR: ext_hi = a_in[xlen-2:0];
      default:                ext_hi = '0;
    endcase
  end

  assign shift_ext  = {ext_hi, a_in};
  assign shift_long = shift_ext >> amount;

  // sll drops the wrapped bits below b
  assign shift_mask = (op == OP_SLL) ? ({xlen{1'b1}} << b_amt) : {xlen{1'b1}};

  always_comb begin
    case (op)
      OP_SLL, OP_SRL, OP_SRA, OP_ROL, OP_ROR: begin
        result = shift_long[xlen-1:0] & shift_mask;
      end
      // selected bit lands in position 0
      OP_BEXT: result = {{(xlen-1){1'b0}}, shift_long[0]};
      default: result = '0;
    endcase
  end

endmodule

// ==== logic/bmu_bitwise.sv ====
`timescale 1ns/1ps

`include "bmu_cfg.svh"

module bmu_bitwise (
  input  bmu_pkg::bmu_op_e op,
  input  bmu_pkg::word_t   a_in,
  input  bmu_pkg::word_t   b_in,
  output bmu_pkg::word_t   result
);

  import bmu_pkg::*;

  localparam int xlen  = `BMU_XLEN;
  localparam int half  = xlen / 2;
  localparam int bytes = xlen / 8;

  word_t  b_opnd;
  word_t  one_hot;
  word_t  rev8_res;
  word_t  orc_res;
  shamt_t bit_idx;
  logic   inv_b;

  // andn, orn and xnor take the complement of rs2
  assign inv_b  = op inside {OP_ANDN, OP_ORN, OP_XNOR};
  assign b_opnd = inv_b ? ~b_in : b_in;

  assign bit_idx = b_in[`BMU_SHAMT_W-1:0];
  assign one_hot = word_t'(1) << bit_idx;

  // byte swap
  always_comb begin
    for (int i = 0; i < bytes; i++) begin
      rev8_res[8*i +: 8] = a_in[8*(bytes-1-i) +: 8];
    end
  end

  // any set bit fills its byte
  always_comb begin
    for (int i = 0; i < bytes; i++) begin
      orc_res[8*i +: 8] = {8{|a_in[8*i +: 8]}};
    end
  end

  always_comb begin
    case (op)
      OP_AND, OP_ANDN: result = a_in & b_opnd;
      OP_OR, OP_ORN:   result = a_in | b_opnd;
      OP_XOR, OP_XNOR: result = a_in ^ b_opnd;
      OP_BSET:         result = a_in | one_hot;
      OP_BCLR:         result = a_in & ~one_hot;
      OP_BINV:         result = a_in ^ one_hot;
      OP_SEXT_B:       result = {{(xlen-8){a_in[7]}}, a_in[7:0]};
      OP_SEXT_H:       result = {{(xlen-16){a_in[15]}}, a_in[15:0]};
      // low halves with rs2 on top
      OP_PACK:         result = {b_in[half-1:0], a_in[half-1:0]};
      OP_PACKU:        result = {b_in[xlen-1:half], a_in[xlen-1:half]};
      OP_PACKH:        result = {{(xlen-16){1'b0}}, b_in[7:0], a_in[7:0]};
      OP_REV8:         result = rev8_res;
      OP_ORC_B:        result = orc_res;
      default:         result = '0;
    endcase
  end

endmodule

// ==== logic/bmu_count.sv ====
`timescale 1ns/1ps

`include "bmu_cfg.svh"

module bmu_count (
  input  bmu_pkg::bmu_op_e op,
  input  bmu_pkg::word_t   a_in,
  output bmu_pkg::cnt_t    count
);

  import bmu_pkg::*;

  localparam int xlen = `BMU_XLEN;

  word_t a_rev;
  word_t scan;
  cnt_t  lz;
  cnt_t  pop;

  // ctz is clz of the mirrored word
  always_comb begin
    for (int i = 0; i < xlen; i++) begin
      a_rev[i] = a_in[xlen-1-i];
    end
  end

  assign scan = (op == OP_CTZ) ? a_rev : a_in;

  // last hit wins, so the highest set bit decides
  always_comb begin
    lz = cnt_t'(xlen);
    for (int i = 0; i < xlen; i++) begin
      if (scan[i]) begin
        lz = cnt_t'(xlen - 1 - i);
      end
    end
  end

  // full-width population count
  always_comb begin
    pop = '0;
    for (int i = 0; i < xlen; i++) begin
      pop = pop + cnt_t'(a_in[i]);
    end
  end

  always_comb begin
    case (op)
      OP_CLZ, OP_CTZ: count = lz;
      OP_CPOP:        count = pop;
      default:        count = '0;
    endcase
  end

endmodule

// ==== logic/bit_manipulation_unit.sv ====
`timescale 1ns/1ps

module bit_manipulation_unit (
  input  logic             clk,
  input  logic             rst,
  input  logic             valid_in,
  input  bmu_pkg::bmu_op_e op,
  input  bmu_pkg::word_t   a_in,
  input  bmu_pkg::word_t   b_in,
  output bmu_pkg::word_t   result_ff,
  output logic             error_ff
);

  import bmu_pkg::*;

  bmu_sel_e sel;
  logic     illegal;
  word_t    add_res;
  word_t    shift_res;
  word_t    logic_res;
  cnt_t     cnt_res;
  word_t    result;

  bmu_decode decode_i (
    .op     (op),
    .sel    (sel),
    .illegal(illegal)
  );

  bmu_adder adder_i (
    .op    (op),
    .a_in  (a_in),
    .b_in  (b_in),
    .result(add_res)
  );

  bmu_shifter shifter_i (
    .op    (op),
    .a_in  (a_in),
    .b_in  (b_in),
    .result(shift_res)
  );

  bmu_bitwise bitwise_i (
    .op    (op),
    .a_in  (a_in),
    .b_in  (b_in),
    .result(logic_res)
  );

  bmu_count count_i (
    .op   (op),
    .a_in (a_in),
    .count(cnt_res)
  );

  // sel is none for illegal ops, so the result is 0
  always_comb begin
    case (sel)
      SEL_ADDER:   result = add_res;
      SEL_SHIFT:   result = shift_res;
      SEL_BITWISE: result = logic_res;
      SEL_COUNT:   result = word_t'(cnt_res);
      default:     result = '0;
    endcase
  end

  // result and error land together one clock after valid_in
  always_ff @(posedge clk) begin
    if (rst) begin
      result_ff <= '0;
      error_ff  <= 1'b0;
    end else if (valid_in) begin
      result_ff <= result;
      error_ff  <= illegal;
    end
  end

endmodule

// ==== tb/bmu_tb.sv ====
`timescale 1ns/1ps

`include "bmu_cfg.svh"

module bmu_tb;

  import bmu_pkg::*;

  // roughly 750 single-cycle operations plus reset and some margin
  localparam int max_cycles = 2000;

  logic    clk;
  logic    rst;
  logic    valid_in;
  bmu_op_e op;
  word_t   a_in;
  word_t   b_in;
  word_t   result_ff;
  logic    error_ff;

  int errors = 0;
  int checks = 0;
  int cycles = 0;

  bit_manipulation_unit dut_i (
    .clk      (clk),
    .rst      (rst),
    .valid_in (valid_in),
    .op       (op),
    .a_in     (a_in),
    .b_in     (b_in),
    .result_ff(result_ff),
    .error_ff (error_ff)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d clock cycles", max_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // expected {error, result} straight from the ISA definitions
  function automatic logic [32:0] model(logic [5:0] code, word_t a, word_t b);
    bmu_op_e    o;
    logic [4:0] sh;
    logic [5:0] rot;
    word_t      r;
    logic       ok;
    int         n;
    o   = bmu_op_e'(code);
    sh  = b[4:0];
    rot = 6'd32 - {1'b0, sh};
    r   = '0;
    n   = 0;
    case (o)
      OP_SH1ADD, OP_SH2ADD, OP_SH3ADD: ok = (`BMU_ZBA_EN != 0);
      OP_BEXT, OP_BSET, OP_BCLR, OP_BINV: ok = (`BMU_ZBS_EN != 0);
      OP_PACKU: ok = (`BMU_ZBP_EN != 0);
      OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_XOR,
      OP_SLL, OP_SRL, OP_SRA: ok = 1'b1;
      // everything else that is defined belongs to Zbb
      default: ok = (code <= 6'd35) && (`BMU_ZBB_EN != 0);
    endcase
    case (o)
      OP_ADD:    r = a + b;
      OP_SUB:    r = a - b;
      OP_SLT:    r = {31'b0, $signed(a) < $signed(b)};
      OP_SLTU:   r = {31'b0, a < b};
      OP_SH1ADD: r = {a[30:0], 1'b0} + b;
      OP_SH2ADD: r = {a[29:0], 2'b0} + b;
      OP_SH3ADD: r = {a[28:0], 3'b0} + b;
      OP_MIN:    r = ($signed(a) < $signed(b)) ? a : b;
      OP_MAX:    r = ($signed(a) < $signed(b)) ? b : a;
      OP_MINU:   r = (a < b) ? a : b;
      OP_MAXU:   r = (a < b) ? b : a;
      OP_AND:    r = a & b;
      OP_OR:     r = a | b;
      OP_XOR:    r = a ^ b;
      OP_ANDN:   r = a & ~b;
      OP_ORN:    r = a | ~b;
      OP_XNOR:   r = ~(a ^ b);
      OP_SLL:    r = a << sh;
      OP_SRL:    r = a >> sh;
      OP_SRA:    r = $signed(a) >>> sh;
      OP_ROL:    r = (a << sh) | (a >> rot);
      OP_ROR:    r = (a >> sh) | (a << rot);
      OP_BEXT:   r = {31'b0, a[sh]};
      OP_BSET, OP_BCLR, OP_BINV: begin
        r = a;
        r[sh] = (o == OP_BSET) ? 1'b1 : (o == OP_BCLR) ? 1'b0 : ~a[sh];
      end
      OP_CLZ: begin
        while (n < 32 && a[31 - n] == 1'b0)
          n++;
        r = word_t'(n);
      end
      OP_CTZ: begin
        while (n < 32 && a[n] == 1'b0)
          n++;
        r = word_t'(n);
      end
      OP_CPOP:   r = word_t'($countones(a));
      OP_SEXT_B: r = {{24{a[7]}}, a[7:0]};
      OP_SEXT_H: r = {{16{a[15]}}, a[15:0]};
      OP_PACK:   r = {b[15:0], a[15:0]};
      OP_PACKU:  r = {b[31:16], a[31:16]};
      OP_PACKH:  r = {16'b0, b[7:0], a[7:0]};
      OP_REV8:   r = {a[7:0], a[15:8], a[23:16], a[31:24]};
      OP_ORC_B: begin
        for (int i = 0; i < 4; i++)
          r[8*i +: 8] = (a[8*i +: 8] != 8'h00) ? 8'hff : 8'h00;
      end
      default:   r = '0;
    endcase
    if (!ok)
      r = '0;
    return {~ok, r};
  endfunction

  task automatic check_word(string what, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // called 1 ns after a rising edge, returns 1 ns after the next one
  task automatic apply(logic [5:0] code, word_t a, word_t b);
    logic [32:0] exp;
    exp      = model(code, a, b);
    op       = bmu_op_e'(code);
    a_in     = a;
    b_in     = b;
    valid_in = 1'b1;
    @(posedge clk);
    #1;
    valid_in = 1'b0;
    checks++;
    if (result_ff !== exp[31:0] || error_ff !== exp[32]) begin
      errors++;
      $display("** Error at %0t: op %0d a=%h b=%h got %h err %b expected %h err %b",
               $time, code, a, b, result_ff, error_ff, exp[31:0], exp[32]);
    end
  endtask

  task automatic reset_and_hold();
    check_word("result after reset", result_ff, '0);
    check_word("error after reset", {31'b0, error_ff}, '0);
    apply(OP_ADD, 32'h1234_0000, 32'h0000_5678);
    // new inputs with valid_in low must not reach the registers
    op   = bmu_op_e'(6'd63);
    a_in = 32'hffff_ffff;
    b_in = 32'h0000_0001;
    repeat (4) @(posedge clk);
    #1;
    check_word("held result", result_ff, 32'h1234_5678);
    check_word("held error", {31'b0, error_ff}, '0);
  endtask

  task automatic arith_ops();
    word_t edge_a[5];
    word_t edge_b[5];
    word_t r;
    edge_a = '{32'h8000_0000, 32'h0000_0005, 32'hffff_ffff, 32'h7fff_ffff, 32'hffff_ffff};
    edge_b = '{32'h0000_0005, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h0000_0001};
    for (int c = OP_ADD; c <= OP_MAXU; c++) begin
      for (int i = 0; i < 5; i++)
        apply(c[5:0], edge_a[i], edge_b[i]);
      r = $urandom();
      apply(c[5:0], r, r);
      for (int i = 0; i < 8; i++)
        apply(c[5:0], $urandom(), $urandom());
    end
  endtask

  task automatic logic_ops();
    bmu_op_e ops[16];
    ops = '{OP_AND, OP_OR, OP_XOR, OP_ANDN, OP_ORN, OP_XNOR, OP_BSET, OP_BCLR,
            OP_BINV, OP_SEXT_B, OP_SEXT_H, OP_PACK, OP_PACKU, OP_PACKH, OP_REV8, OP_ORC_B};
    foreach (ops[k]) begin
      apply(ops[k], 32'h0000_0080, 32'h0000_001f);
      apply(ops[k], 32'h0000_8000, 32'h0000_0000);
      apply(ops[k], 32'h1234_5678, 32'h9abc_def0);
      apply(ops[k], 32'h00ff_0010, 32'hffff_fff3);
      for (int i = 0; i < 8; i++)
        apply(ops[k], $urandom(), $urandom());
    end
  endtask

  task automatic shift_sweep();
    word_t b;
    for (int c = OP_SLL; c <= OP_BEXT; c++) begin
      for (int s = 0; s < 32; s++) begin
        // upper bits of b_in are noise and must be ignored
        b = $urandom();
        b[4:0] = s[4:0];
        apply(c[5:0], $urandom(), b);
      end
    end
  endtask

  task automatic count_ops();
    for (int c = OP_CLZ; c <= OP_CPOP; c++) begin
      apply(c[5:0], 32'h0000_0000, $urandom());
      apply(c[5:0], 32'hffff_ffff, $urandom());
      for (int i = 0; i < 32; i++)
        apply(c[5:0], word_t'(1) << i, 32'h0);
      for (int i = 0; i < 8; i++)
        apply(c[5:0], $urandom(), 32'h0);
    end
  endtask

  task automatic undefined_codes();
    for (int c = 36; c < 64; c++) begin
      apply(c[5:0], $urandom(), $urandom());
      // legal op right after clears the flag
      apply(OP_XOR, $urandom(), $urandom());
    end
  endtask

  initial begin
    void'($urandom(32'hdaf5));
    rst      = 1'b1;
    valid_in = 1'b0;
    op       = OP_ADD;
    a_in     = '0;
    b_in     = '0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_and_hold();
    arith_ops();
    logic_ops();
    shift_sweep();
    count_ops();
    undefined_codes();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== bit_manipulation_unit.f ====
+incdir+include
logic/bmu_pkg.sv
logic/bmu_decode.sv
logic/bmu_adder.sv
logic/bmu_shifter.sv
logic/bmu_bitwise.sv
logic/bmu_count.sv
logic/bit_manipulation_unit.sv
tb/bmu_tb.sv

// ==== Makefile ====
# Verilator build and run of the bit manipulation unit testbench

VERILATOR ?= verilator
TOP       ?= bmu_tb
FILELIST  ?= bit_manipulation_unit.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
